// ==== hw/image_pipe_consts.svh ====
// Sizes, ones-phase beat counts and config word positions, included by the image pipe sources
`ifndef IMAGE_PIPE_CONSTS_SVH
`define IMAGE_PIPE_CONSTS_SVH

// **************************************************
// Datapath sizes
// **************************************************
`define UNITS         4   // Output words per lane
`define WORD_WIDTH    8
`define KERNEL_H_MAX  3   // Odd
`define UNITS_EDGES   (`UNITS + `KERNEL_H_MAX - 1)
`define BITS_KERNEL_H 2   // Holds kernel_h - 1

// Ones beats minus one, per kernel size
`define BEATS_CONFIG_3X3_1 3
`define BEATS_CONFIG_1X1_1 1
`define BITS_CONFIG_COUNT  2

// **************************************************
// Config beat layout, one field per word
// **************************************************
`define I_IS_NOT_MAX 0
`define I_IS_MAX     1
`define I_IS_LRELU   2
`define I_KERNEL_H_1 3

`define USER_WIDTH `I_KERNEL_H_1  // Flag fields sit below the kernel field
`define ONES_UNIT  (`KERNEL_H_MAX / 2)  // First unpadded unit

`endif

// ==== hw/image_pipe_pkg.sv ====
// Word, frame, config and state types shared by the image pipe modules
`default_nettype none

`include "image_pipe_consts.svh"

package image_pipe_pkg;

  // One image word
  typedef logic [`WORD_WIDTH-1:0] word_t;

  // Input beat with edge words, word 0 in the low bits
  typedef word_t [`UNITS_EDGES-1:0] in_frame_t;

  // Output beat, one word per unit
  typedef word_t [`UNITS-1:0] out_frame_t;

  typedef logic [`BITS_KERNEL_H-1:0] kernel_h_1_t;

  // Fields taken from the config beat
  typedef struct packed {
    logic        is_not_max;
    logic        is_max;
    logic        is_lrelu;
    kernel_h_1_t kernel_h_1;
  } pipe_cfg_t;

  typedef enum logic [1:0] {
    SET_S,   // Waiting for the config beat
    ONES_S,  // Activation config ones
    PASS_S   // Image beats
  } pipe_state_e;

endpackage

`default_nettype wire

// ==== hw/image_beat_if.sv ====
// Two-lane image beat with its flags, passed from the pipe to the shift buffer
`timescale 1ns/1ps
`default_nettype none

interface image_beat_if import image_pipe_pkg::*; ();

  logic        valid;
  logic        ready;       // From the shift counter
  in_frame_t   data_1;
  in_frame_t   data_2;
  logic        is_not_max;
  logic        is_max;
  logic        is_lrelu;
  kernel_h_1_t kernel_h_1;  // Shifts minus one for this beat

  modport src (
    output valid,
    output data_1,
    output data_2,
    output is_not_max,
    output is_max,
    output is_lrelu,
    output kernel_h_1,
    input  ready
  );

  modport dst (
    input  valid,
    input  data_1,
    input  data_2,
    input  is_not_max,
    input  is_max,
    input  is_lrelu,
    input  kernel_h_1,
    output ready
  );

endinterface

`default_nettype wire

// ==== hw/pipe_ctrl_fsm.sv ====
// Pipe state machine, steers the stream readies, the beat valid and the config/count enables
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_fsm import image_pipe_pkg::*; (
  input  logic        aclk,
  input  logic        rst,
  input  logic        s1_valid,
  input  logic        s1_last,
  input  logic        s2_valid,
  input  logic        is_max,     // Captured mode
  input  logic        ones_last,
  image_beat_if.src   beat,
  output logic        s1_ready,
  output logic        s2_ready,
  output logic        cfg_en,
  output logic        cnt_en,
  output logic        cnt_clr,
  output pipe_state_e state
);

  pipe_state_e state_next;

  // **************************************************
  // Next state and handshake decode
  // **************************************************
  always_comb begin
    state_next = state;
    beat.valid = 1'b0;
    s1_ready   = 1'b0;
    s2_ready   = 1'b0;
    cfg_en     = 1'b0;
    cnt_en     = 1'b0;
    cnt_clr    = 1'b0;
    unique case (state)
      SET_S: begin
        s1_ready = beat.ready;               // Config beat is swallowed
        cfg_en   = s1_valid && beat.ready;
        cnt_clr  = 1'b1;
        if (s1_valid && beat.ready) state_next = ONES_S;
      end
      ONES_S: begin
        beat.valid = 1'b1;
        cnt_en     = beat.ready;
        if (ones_last && beat.ready) state_next = PASS_S;
      end
      default: begin
        // Max mode needs a beat from both streams at once
        if (is_max) begin
          beat.valid = s1_valid && s2_valid;
          s1_ready   = beat.ready && s2_valid;
          s2_ready   = beat.ready && s1_valid;
        end else begin
          beat.valid = s1_valid;
          s1_ready   = beat.ready;
        end
        if (s1_valid && s1_last && beat.ready && (!is_max || s2_valid)) state_next = SET_S;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (rst) state <= SET_S;
    else     state <= state_next;
  end

endmodule

`default_nettype wire

// ==== hw/ones_beat_counter.sv ====
// Counts accepted ones beats and flags the last one for the captured kernel size
`timescale 1ns/1ps
`default_nettype none

`include "image_pipe_consts.svh"

module ones_beat_counter import image_pipe_pkg::*; (
  input  logic        aclk,
  input  logic        rst,
  input  logic        cnt_en,      // Ones beat accepted
  input  logic        cnt_clr,
  input  kernel_h_1_t kernel_h_1,
  output logic        ones_last
);

  logic [`BITS_CONFIG_COUNT-1:0] count;
  logic [`BITS_CONFIG_COUNT-1:0] beats_total;

  // 1x1 kernels need fewer config beats
  assign beats_total = (kernel_h_1 == '0) ? `BITS_CONFIG_COUNT'(`BEATS_CONFIG_1X1_1)
                                           : `BITS_CONFIG_COUNT'(`BEATS_CONFIG_3X3_1);

  always_ff @(posedge aclk) begin
    if (rst || cnt_clr) count <= '0;
    else if (cnt_en)    count <= count + 1'b1;
  end

  assign ones_last = (count == beats_total);

endmodule

`default_nettype wire

// ==== hw/config_capture.sv ====
// Samples the config fields from the config beat and holds them for the whole image
`timescale 1ns/1ps
`default_nettype none

`include "image_pipe_consts.svh"

module config_capture import image_pipe_pkg::*; (
  input  logic      aclk,
  input  logic      rst,
  input  logic      cfg_en,   // Config beat accepted
  input  in_frame_t s1_data,
  output pipe_cfg_t cfg
);

  pipe_cfg_t cfg_in;

  // One field per word, low bits only
  always_comb begin
    cfg_in.is_not_max = s1_data[`I_IS_NOT_MAX][0];
    cfg_in.is_max     = s1_data[`I_IS_MAX][0];
    cfg_in.is_lrelu   = s1_data[`I_IS_LRELU][0];
    cfg_in.kernel_h_1 = s1_data[`I_KERNEL_H_1][`BITS_KERNEL_H-1:0];
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      cfg <= '0;
    end else if (cfg_en) begin
      cfg <= cfg_in;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lane_mux.sv ====
// Builds the two output lanes from the ones pattern or the two input streams
`timescale 1ns/1ps
`default_nettype none

`include "image_pipe_consts.svh"

module lane_mux import image_pipe_pkg::*; (
  input  pipe_state_e state,
  input  logic        is_max,
  input  in_frame_t   s1_data,
  input  in_frame_t   s2_data,
  output in_frame_t   data_1,
  output in_frame_t   data_2
);

  in_frame_t ones_frame;

  // One in the first unpadded unit, zeros elsewhere to save toggling
  always_comb begin
    ones_frame             = '0;
    ones_frame[`ONES_UNIT] = word_t'(1);
  end

  // **************************************************
  // Lane select
  // **************************************************
  assign data_1 = (state == ONES_S) ? ones_frame : s1_data;

  always_comb begin
    if (state == ONES_S) data_2 = ones_frame;
    else if (is_max)     data_2 = s2_data;   // Pairs of images
    else                 data_2 = s1_data;   // Same image on both lanes
  end

endmodule

`default_nettype wire

// ==== hw/shift_counter.sv ====
// Counts the remaining shifts of the held beat and gates the shift buffer's input ready
`timescale 1ns/1ps
`default_nettype none

module shift_counter import image_pipe_pkg::*; (
  input  logic        aclk,
  input  logic        rst,
  image_beat_if.dst   beat,
  input  logic        m_ready,
  input  logic        m_valid,
  output kernel_h_1_t count,     // Shifts still to come
  output logic        advance
);

  // Output register can move
  assign advance = m_ready || !m_valid;

  // New beats only once the held one is fully shifted out
  assign beat.ready = (count == '0) && advance;

  always_ff @(posedge aclk) begin
    if (rst) begin
      count <= '0;
    end else if (advance) begin
      if (count != '0)     count <= count - 1'b1;
      else if (beat.valid) count <= beat.kernel_h_1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/shift_buffer.sv ====
// De-centres the accepted two-lane beat, then shifts it down one word per output beat
`timescale 1ns/1ps
`default_nettype none

`include "image_pipe_consts.svh"

module shift_buffer import image_pipe_pkg::*; (
  input  logic                   aclk,
  input  logic                   rst,
  image_beat_if.dst              beat,
  input  kernel_h_1_t            count,
  input  logic                   advance,
  output logic                   m_valid,
  output out_frame_t             m_data_1,
  output out_frame_t             m_data_2,
  output logic [`USER_WIDTH-1:0] m_user
);

  in_frame_t              buf_1;
  in_frame_t              buf_2;
  logic [`USER_WIDTH-1:0] user_in;
  logic                   load;

  // **************************************************
  // Word helpers
  // **************************************************

  // Input is padded around the centre, shifting runs one way only,
  // so word u starts from u + KERNEL_H_MAX/2 - kernel_h_1/2
  function automatic in_frame_t decentre(input in_frame_t frame, input kernel_h_1_t kh_1);
    in_frame_t res;
    int        src;
    res = '0;
    for (int u = 0; u < `UNITS_EDGES; u++) begin
      src = u + `KERNEL_H_MAX / 2 - int'(kh_1 >> 1);
      if (src < `UNITS_EDGES) res[u] = frame[src];
    end
    return res;
  endfunction

  // Each word takes its upper neighbour
  function automatic in_frame_t shift_down(input in_frame_t frame);
    return in_frame_t'({word_t'(0), frame[`UNITS_EDGES-1:1]});
  endfunction

  assign load    = (count == '0);
  assign user_in = {beat.is_lrelu, beat.is_max, beat.is_not_max};

  // **************************************************
  // Buffers
  // **************************************************
  always_ff @(posedge aclk) begin
    if (advance) begin
      if (load) begin
        buf_1 <= decentre(beat.data_1, beat.kernel_h_1);
        buf_2 <= decentre(beat.data_2, beat.kernel_h_1);
      end else begin
        buf_1 <= shift_down(buf_1);
        buf_2 <= shift_down(buf_2);
      end
    end
  end

  // Valid and flags move with the data
  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid <= 1'b0;
      m_user  <= '0;
    end else if (advance) begin
      if (load) begin
        m_valid <= beat.valid;
        m_user  <= user_in;
      end else begin
        m_valid <= 1'b1;  // Shifted copies of the held beat
      end
    end
  end

  assign m_data_1 = buf_1[`UNITS-1:0];
  assign m_data_2 = buf_2[`UNITS-1:0];

endmodule

`default_nettype wire

// ==== hw/image_pipe_top.sv ====
// Image path front end, joins the stream pipe and the shift buffer behind plain stream ports
`timescale 1ns/1ps
`default_nettype none

`include "image_pipe_consts.svh"

module image_pipe_top import image_pipe_pkg::*; (
  input  logic                   aclk,
  input  logic                   rst,
  input  logic                   s1_valid,
  output logic                   s1_ready,
  input  logic                   s1_last,
  input  in_frame_t              s1_data,
  input  logic                   s2_valid,
  output logic                   s2_ready,
  input  in_frame_t              s2_data,
  output logic                   m_valid,
  input  logic                   m_ready,
  output out_frame_t             m_data_1,
  output out_frame_t             m_data_2,
  output logic [`USER_WIDTH-1:0] m_user
);

  logic        cfg_en;
  logic        cnt_en;
  logic        cnt_clr;
  logic        ones_last;
  pipe_cfg_t   cfg;
  pipe_state_e state;
  kernel_h_1_t count;
  logic        advance;

  image_beat_if beat ();

  // **************************************************
  // Pipe
  // **************************************************
  pipe_ctrl_fsm fsm_i (
    .aclk      (aclk),
    .rst       (rst),
    .s1_valid  (s1_valid),
    .s1_last   (s1_last),
    .s2_valid  (s2_valid),
    .is_max    (cfg.is_max),
    .ones_last (ones_last),
    .beat      (beat),
    .s1_ready  (s1_ready),
    .s2_ready  (s2_ready),
    .cfg_en    (cfg_en),
    .cnt_en    (cnt_en),
    .cnt_clr   (cnt_clr),
    .state     (state)
  );

  ones_beat_counter ones_i (
    .aclk       (aclk),
    .rst        (rst),
    .cnt_en     (cnt_en),
    .cnt_clr    (cnt_clr),
    .kernel_h_1 (cfg.kernel_h_1),
    .ones_last  (ones_last)
  );

  config_capture cfg_i (
    .aclk    (aclk),
    .rst     (rst),
    .cfg_en  (cfg_en),
    .s1_data (s1_data),
    .cfg     (cfg)
  );

  lane_mux mux_i (
    .state   (state),
    .is_max  (cfg.is_max),
    .s1_data (s1_data),
    .s2_data (s2_data),
    .data_1  (beat.data_1),
    .data_2  (beat.data_2)
  );

  assign beat.is_not_max = cfg.is_not_max;
  assign beat.is_max     = cfg.is_max;
  assign beat.is_lrelu   = cfg.is_lrelu;
  assign beat.kernel_h_1 = (state == ONES_S) ? '0 : cfg.kernel_h_1;  // Ones go out once each

  // **************************************************
  // Shift buffer
  // **************************************************
  shift_counter shift_cnt_i (
    .aclk    (aclk),
    .rst     (rst),
    .beat    (beat),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .count   (count),
    .advance (advance)
  );

  shift_buffer shift_buf_i (
    .aclk     (aclk),
    .rst      (rst),
    .beat     (beat),
    .count    (count),
    .advance  (advance),
    .m_valid  (m_valid),
    .m_data_1 (m_data_1),
    .m_data_2 (m_data_2),
    .m_user   (m_user)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
// Testbench clock and reset source, 100 ns period with reset held for the first 10 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic aclk,
  output logic rst
);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge aclk);
    #10 rst = 1'b0;  // Released like any other driven input
  end

endmodule

`default_nettype wire

// ==== verif/image_pipe_tb.sv ====
// Image pipe testbench that drives both streams and checks every output beat against a queue model
`timescale 1ns/1ps
`default_nettype none

`include "image_pipe_consts.svh"

module image_pipe_tb import image_pipe_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 300;

  logic aclk, rst;
  logic s1_valid, s1_ready, s1_last, s2_valid, s2_ready, m_valid, m_ready;
  in_frame_t s1_data, s2_data;
  out_frame_t m_data_1, m_data_2;
  logic [`USER_WIDTH-1:0] m_user;

  integer seed = 69202;
  string test_name;
  logic max_mode, stall_en;
  int cfg_kh1, stall_idx;
  logic [`USER_WIDTH-1:0] cfg_user;
  bit stall_pat [256];
  out_frame_t exp_d1_q[$], exp_d2_q[$];
  logic [`USER_WIDTH-1:0] exp_user_q[$];

  tb_clock_gen clk_gen_i (.aclk(aclk), .rst(rst));

  image_pipe_top image_pipe_top_i (
    .aclk(aclk), .rst(rst),
    .s1_valid(s1_valid), .s1_ready(s1_ready), .s1_last(s1_last), .s1_data(s1_data),
    .s2_valid(s2_valid), .s2_ready(s2_ready), .s2_data(s2_data),
    .m_valid(m_valid), .m_ready(m_ready), .m_data_1(m_data_1), .m_data_2(m_data_2),
    .m_user(m_user)
  );

  // **************************************************
  // Reporting and model helpers
  // **************************************************
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
      else stop_run($sformatf("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act));
  endtask

  function automatic in_frame_t random_frame();
    in_frame_t f;
    for (int w = 0; w < `UNITS_EDGES; w++) f[w] = word_t'($random(seed));
    return f;
  endfunction

  // Word u of output j is input word u + KERNEL_H_MAX/2 - kh1/2 + j, zero past the top
  function automatic out_frame_t expected_out(input in_frame_t f, input int kh1, input int j);
    out_frame_t res;
    int idx;
    for (int u = 0; u < `UNITS; u++) begin
      idx = u + `KERNEL_H_MAX / 2 - kh1 / 2 + j;
      res[u] = (idx < `UNITS_EDGES) ? f[idx] : word_t'(0);
    end
    return res;
  endfunction

  task automatic push_expected(input out_frame_t d1, input out_frame_t d2);
    exp_d1_q.push_back(d1);
    exp_d2_q.push_back(d2);
    exp_user_q.push_back(cfg_user);
  endtask

  // **************************************************
  // Stream drivers
  // **************************************************
  task automatic wait_accept(input string what, input logic pair);
    int cycles;
    cycles = 0;
    @(negedge aclk);
    while (!s1_ready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) stop_run($sformatf("Timeout: %s never accepted", what));
      @(negedge aclk);
    end
    if (pair) check_value("s2_ready with s1_ready", 1, s2_ready);  // Both streams together
    @(posedge aclk);
    #10;
  endtask

  task automatic send_config(input logic not_max, input logic is_max, input logic lrelu,
                             input int kh1);
    in_frame_t f, ones;
    f = random_frame();
    f[`I_IS_NOT_MAX] = word_t'(not_max);
    f[`I_IS_MAX]     = word_t'(is_max);
    f[`I_IS_LRELU]   = word_t'(lrelu);
    f[`I_KERNEL_H_1] = word_t'(kh1);
    max_mode = is_max;
    cfg_kh1  = kh1;
    cfg_user = {lrelu, is_max, not_max};
    s1_valid = 1'b1;
    s1_data  = f;
    s1_last  = 1'b0;
    wait_accept("config beat", 1'b0);
    ones = '0;
    ones[`ONES_UNIT] = word_t'(1);
    repeat ((kh1 == 0) ? 2 : 4) push_expected(expected_out(ones, 0, 0), expected_out(ones, 0, 0));
  endtask

  task automatic send_image(input in_frame_t f1, input in_frame_t f2, input logic last);
    s1_valid = 1'b1;
    s1_data  = f1;
    s1_last  = last;
    s2_valid = 1'b1;  // Offered in both modes, used only in max mode
    s2_data  = f2;
    wait_accept("image beat", max_mode);
    for (int j = 0; j <= cfg_kh1; j++)
      push_expected(expected_out(f1, cfg_kh1, j), expected_out(max_mode ? f2 : f1, cfg_kh1, j));
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    s1_valid = 1'b0;
    s2_valid = 1'b0;
    s1_last  = 1'b0;
    while (exp_d1_q.size() != 0) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) stop_run($sformatf("Timeout: %s outputs not drained", test_name));
      @(negedge aclk);
    end
    @(posedge aclk);
    #10;
  endtask

  // Output ready with random stalls from a pattern drawn at time zero
  initial begin
    m_ready   = 1'b1;
    stall_idx = 0;
    forever begin
      @(posedge aclk);
      #10;
      m_ready   = stall_en ? stall_pat[stall_idx] : 1'b1;
      stall_idx = (stall_idx + 1) % 256;
    end
  end

  // **************************************************
  // Output checks
  // **************************************************
  always @(negedge aclk) begin
    if (!rst && m_valid && m_ready) begin
      assert (exp_d1_q.size() > 0)
        else stop_run($sformatf("%s: output beat appeared with none expected", test_name));
      check_value("m_data_1", exp_d1_q[0], m_data_1);
      check_value("m_data_2", exp_d2_q[0], m_data_2);
      check_value("m_user", exp_user_q[0], m_user);
      void'(exp_d1_q.pop_front());
      void'(exp_d2_q.pop_front());
      void'(exp_user_q.pop_front());
    end
  end

  // Held beat stays put until taken
  assert property (@(posedge aclk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data_1) && $stable(m_data_2)
                               && $stable(m_user)))
    else stop_run($sformatf("%s: output beat dropped or changed while stalled", test_name));

  assert property (@(posedge aclk) disable iff (rst) !max_mode |-> !s2_ready)
    else stop_run($sformatf("%s: s2_ready went high outside max mode", test_name));

  // **************************************************
  // Stimulus
  // **************************************************
  initial begin
    int cycles;
    s1_valid = 1'b0;
    s1_last  = 1'b0;
    s1_data  = '0;
    s2_valid = 1'b0;
    s2_data  = '0;
    test_name = "reset";
    max_mode = 1'b0;
    stall_en = 1'b0;
    cfg_kh1  = 0;
    cfg_user = '0;
    for (int i = 0; i < 256; i++) stall_pat[i] = (($random(seed) & 3) != 0);

    cycles = 0;
    @(negedge aclk);
    while (rst) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) stop_run("Timeout: reset never released");
      @(negedge aclk);
    end
    check_value("m_valid after reset", 0, m_valid);
    check_value("s2_ready after reset", 0, s2_ready);
    check_value("m_user after reset", 0, m_user);
    repeat (5) @(posedge aclk);  // No output may appear before a config beat
    #10;

    test_name = "max_3x3";
    send_config(1'b0, 1'b1, 1'b1, 2);
    for (int i = 0; i < 3; i++) send_image(random_frame(), random_frame(), i == 2);
    wait_drain();

    test_name = "nonmax_1x1";
    send_config(1'b1, 1'b0, 1'b0, 0);
    for (int i = 0; i < 4; i++) send_image(random_frame(), random_frame(), i == 3);
    wait_drain();

    test_name = "random_stall";
    stall_en = 1'b1;
    send_config(1'b0, 1'b1, 1'b0, 2);
    for (int i = 0; i < 4; i++) send_image(random_frame(), random_frame(), i == 3);
    send_config(1'b1, 1'b0, 1'b1, 0);  // Straight after last
    for (int i = 0; i < 3; i++) send_image(random_frame(), random_frame(), i == 2);
    wait_drain();
    stall_en = 1'b0;
    repeat (10) @(posedge aclk);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/image_pipe_pkg.sv
hw/image_beat_if.sv
hw/pipe_ctrl_fsm.sv
hw/ones_beat_counter.sv
hw/config_capture.sv
hw/lane_mux.sv
hw/shift_counter.sv
hw/shift_buffer.sv
hw/image_pipe_top.sv
verif/tb_clock_gen.sv
verif/image_pipe_tb.sv
